/* common/pipe_cfg.svh */
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Register address width
// 5 bits gives 32 architectural registers, r0 reads as zero
`define PIPE_REG_ADDR 5

// Integer data path width, also the width of load and store words
`define PIPE_DATA_W 32

// Data memory size in words
// The memory is word addressed and uses only the low address bits
`define PIPE_MEM_DEPTH 64

`endif

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // ALU operations, carried from issue through ID/EX
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,  // Shift left by b[4:0]
        alu_srl = 3'd6,  // Logical shift right by b[4:0]
        alu_slt = 3'd7   // Signed set less than
    } alu_op_t;

    // Operand source for the EX bypass muxes
    typedef enum logic [1:0] {
        fwd_reg = 2'b00, // Register file value latched in ID/EX
        fwd_mem = 2'b01, // EX/MEM result, newest producer
        fwd_wb  = 2'b10  // MEM/WB result
    } fwd_sel_t;

    // Store data source in MEM
    typedef enum logic {
        mem_fwd_none = 1'b0, // Keep the store data held in EX/MEM
        mem_fwd_wb   = 1'b1  // Take the value in MEM/WB, load then store
    } mem_fwd_sel_t;

endpackage

`default_nettype wire

/* src/forwarding_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module forwarding_control
(
    input  wire [`PIPE_REG_ADDR-1:0] id_ex_src1,       // EX stage source 1
    input  wire [`PIPE_REG_ADDR-1:0] id_ex_src2,       // EX stage source 2
    input  wire [`PIPE_REG_ADDR-1:0] ex_mem_src2,      // Store data register in MEM
    input  wire                      ex_mem_regwrite,  // MEM stage writes the register file
    input  wire [`PIPE_REG_ADDR-1:0] ex_mem_dest_reg,  // MEM stage destination
    input  wire                      ex_mem_writemem,  // MEM stage is a store
    input  wire                      mem_wb_regwrite,  // WB stage writes the register file
    input  wire [`PIPE_REG_ADDR-1:0] mem_wb_dest_reg,  // WB stage destination
    output pipe_pkg::fwd_sel_t       forward_src1,     // Operand a mux select
    output pipe_pkg::fwd_sel_t       forward_src2,     // Operand b and store data mux select
    output pipe_pkg::mem_fwd_sel_t   forward_mem       // Store data mux select in MEM
);

    // Producer match, register zero excluded
    logic ex_mem_live;
    logic mem_wb_live;

    // Newest producer first, so a hit in MEM hides an older hit in WB
    function automatic pipe_pkg::fwd_sel_t pick_source
    (
        input logic [`PIPE_REG_ADDR-1:0] src
    );
        if (ex_mem_live && ex_mem_dest_reg == src)
            return pipe_pkg::fwd_mem;
        else if (mem_wb_live && mem_wb_dest_reg == src)
            return pipe_pkg::fwd_wb;
        else
            return pipe_pkg::fwd_reg;
    endfunction

    assign ex_mem_live = ex_mem_regwrite && (ex_mem_dest_reg != '0);
    assign mem_wb_live = mem_wb_regwrite && (mem_wb_dest_reg != '0);

    always_comb
    begin
        forward_src1 = pick_source(id_ex_src1);
        forward_src2 = pick_source(id_ex_src2);
    end

    // Store right after a load of its data register
    // The EX bypass picked up the load address, so MEM takes the loaded word instead
    // Independent of the operand selects, a store writes no register
    always_comb
    begin
        if (ex_mem_writemem && mem_wb_live && mem_wb_dest_reg == ex_mem_src2)
            forward_mem = pipe_pkg::mem_fwd_wb;
        else
            forward_mem = pipe_pkg::mem_fwd_none;
    end

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module register_file
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire [`PIPE_REG_ADDR-1:0] rd_addr1,  // Issue source 1
    input  wire [`PIPE_REG_ADDR-1:0] rd_addr2,  // Issue source 2
    input  wire                      wr_en,     // From MEM/WB regwrite
    input  wire [`PIPE_REG_ADDR-1:0] wr_addr,
    input  wire [`PIPE_DATA_W-1:0]   wr_data,
    output logic [`PIPE_DATA_W-1:0]  rd_data1,
    output logic [`PIPE_DATA_W-1:0]  rd_data2
);

    localparam int num_regs = 1 << `PIPE_REG_ADDR;

    logic [`PIPE_DATA_W-1:0] regs [num_regs];

    // r0 is hardwired, a write in flight is returned directly
    function automatic logic [`PIPE_DATA_W-1:0] read_port
    (
        input logic [`PIPE_REG_ADDR-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (wr_en && wr_addr == addr)
            return wr_data;  // Write-through, covers the three-apart dependence
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    always_comb
    begin
        rd_data1 = read_port(rd_addr1);
        rd_data2 = read_port(rd_addr2);
    end

endmodule

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module alu
(
    input  wire pipe_pkg::alu_op_t  op,
    input  wire [`PIPE_DATA_W-1:0]  a,       // Bypassed operand a
    input  wire [`PIPE_DATA_W-1:0]  b,       // Bypassed operand b or immediate
    output logic [`PIPE_DATA_W-1:0] result
);

    localparam int shamt_w = $clog2(`PIPE_DATA_W);

    logic [shamt_w-1:0] shamt;  // Low 5 bits of b
    logic               less;   // Signed compare for slt

    assign shamt = b[shamt_w-1:0];
    assign less  = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            pipe_pkg::alu_add:
                result = a + b;
            pipe_pkg::alu_sub:
                result = a - b;
            pipe_pkg::alu_and:
                result = a & b;
            pipe_pkg::alu_or:
                result = a | b;
            pipe_pkg::alu_xor:
                result = a ^ b;
            pipe_pkg::alu_sll:
                result = a << shamt;
            pipe_pkg::alu_srl:
                result = a >> shamt;  // Zero fill
            pipe_pkg::alu_slt:
                result = {{(`PIPE_DATA_W-1){1'b0}}, less};
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module execute_stage
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire pipe_pkg::alu_op_t    id_ex_op,
    input  wire [`PIPE_DATA_W-1:0]    id_ex_a,          // Register file value, source 1
    input  wire [`PIPE_DATA_W-1:0]    id_ex_b,          // Register file value, source 2
    input  wire [`PIPE_DATA_W-1:0]    id_ex_imm,
    input  wire                       id_ex_use_imm,    // Immediate replaces operand b
    input  wire [`PIPE_REG_ADDR-1:0]  id_ex_src1,
    input  wire [`PIPE_REG_ADDR-1:0]  id_ex_src2,
    input  wire [`PIPE_REG_ADDR-1:0]  id_ex_dest,
    input  wire                       id_ex_regwrite,
    input  wire                       id_ex_memread,
    input  wire                       id_ex_memwrite,
    input  wire [`PIPE_DATA_W-1:0]    mem_wb_result,    // Load data or ALU result
    input  wire                       mem_wb_regwrite,
    input  wire [`PIPE_REG_ADDR-1:0]  mem_wb_dest,
    output logic [`PIPE_DATA_W-1:0]   ex_mem_result,    // ALU result, memory address
    output logic [`PIPE_DATA_W-1:0]   ex_mem_store_data,
    output logic [`PIPE_REG_ADDR-1:0] ex_mem_src2,
    output logic [`PIPE_REG_ADDR-1:0] ex_mem_dest,
    output logic                      ex_mem_regwrite,
    output logic                      ex_mem_memread,
    output logic                      ex_mem_memwrite,
    output pipe_pkg::mem_fwd_sel_t    forward_mem       // Used by the store data mux in MEM
);

    pipe_pkg::fwd_sel_t      forward_src1;
    pipe_pkg::fwd_sel_t      forward_src2;
    logic [`PIPE_DATA_W-1:0] op_a;        // Bypassed source 1
    logic [`PIPE_DATA_W-1:0] fwd_b;       // Bypassed source 2, also store data
    logic [`PIPE_DATA_W-1:0] op_b;        // After immediate select
    logic [`PIPE_DATA_W-1:0] alu_result;

    // Three-way bypass mux shared by both operands
    function automatic logic [`PIPE_DATA_W-1:0] bypass
    (
        input pipe_pkg::fwd_sel_t      sel,
        input logic [`PIPE_DATA_W-1:0] reg_value
    );
        case (sel)
            pipe_pkg::fwd_mem: return ex_mem_result;
            pipe_pkg::fwd_wb:  return mem_wb_result;
            default:           return reg_value;
        endcase
    endfunction

    forwarding_control forwarding_control_inst
    (
        .id_ex_src1      (id_ex_src1),
        .id_ex_src2      (id_ex_src2),
        .ex_mem_src2     (ex_mem_src2),
        .ex_mem_regwrite (ex_mem_regwrite),
        .ex_mem_dest_reg (ex_mem_dest),
        .ex_mem_writemem (ex_mem_memwrite),
        .mem_wb_regwrite (mem_wb_regwrite),
        .mem_wb_dest_reg (mem_wb_dest),
        .forward_src1    (forward_src1),
        .forward_src2    (forward_src2),
        .forward_mem     (forward_mem)
    );

    always_comb
    begin
        op_a = bypass(forward_src1, id_ex_a);
        fwd_b = bypass(forward_src2, id_ex_b);
        op_b = id_ex_use_imm ? id_ex_imm : fwd_b;  // Loads and stores add the offset
    end

    alu alu_inst
    (
        .op     (id_ex_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // EX/MEM control, cleared on reset so no stray write follows it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_mem_regwrite <= 1'b0;
            ex_mem_memread  <= 1'b0;
            ex_mem_memwrite <= 1'b0;
        end
        else
        begin
            ex_mem_regwrite <= id_ex_regwrite;
            ex_mem_memread  <= id_ex_memread;
            ex_mem_memwrite <= id_ex_memwrite;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk)
    begin
        ex_mem_result     <= alu_result;
        ex_mem_store_data <= fwd_b;
        ex_mem_src2       <= id_ex_src2;   // Kept for the load then store check
        ex_mem_dest       <= id_ex_dest;
    end

endmodule

`default_nettype wire

/* src/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module data_memory
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     wr_en,    // Store in MEM
    input  wire [`PIPE_DATA_W-1:0]  addr,     // Word address from EX/MEM
    input  wire [`PIPE_DATA_W-1:0]  wr_data,
    output logic [`PIPE_DATA_W-1:0] rd_data   // Valid in the same cycle
);

    localparam int addr_w = $clog2(`PIPE_MEM_DEPTH);

    logic [`PIPE_DATA_W-1:0] mem [`PIPE_MEM_DEPTH];
    logic [addr_w-1:0]       word_addr;  // Upper address bits wrap

    assign word_addr = addr[addr_w-1:0];
    assign rd_data   = mem[word_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `PIPE_MEM_DEPTH; i++)
                mem[i] <= '0;
        end
        else if (wr_en)
            mem[word_addr] <= wr_data;
    end

endmodule

`default_nettype wire

/* src/pipeline_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module pipeline_core
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       issue_valid,     // One decoded instruction per edge
    input  wire pipe_pkg::alu_op_t    issue_op,
    input  wire [`PIPE_REG_ADDR-1:0]  issue_src1,
    input  wire [`PIPE_REG_ADDR-1:0]  issue_src2,
    input  wire [`PIPE_REG_ADDR-1:0]  issue_dest,
    input  wire [`PIPE_DATA_W-1:0]    issue_imm,
    input  wire                       issue_use_imm,
    input  wire                       issue_regwrite,
    input  wire                       issue_memread,
    input  wire                       issue_memwrite,
    output logic                      retire_valid,    // Three cycles after the issue edge
    output logic [`PIPE_REG_ADDR-1:0] retire_dest,
    output logic [`PIPE_DATA_W-1:0]   retire_data,
    output logic                      retire_regwrite
);

    logic [`PIPE_DATA_W-1:0]   rf_data1;
    logic [`PIPE_DATA_W-1:0]   rf_data2;
    pipe_pkg::alu_op_t         id_ex_op;
    logic [`PIPE_DATA_W-1:0]   id_ex_a;
    logic [`PIPE_DATA_W-1:0]   id_ex_b;
    logic [`PIPE_DATA_W-1:0]   id_ex_imm;
    logic                      id_ex_use_imm;
    logic [`PIPE_REG_ADDR-1:0] id_ex_src1;
    logic [`PIPE_REG_ADDR-1:0] id_ex_src2;
    logic [`PIPE_REG_ADDR-1:0] id_ex_dest;
    logic                      id_ex_regwrite;
    logic                      id_ex_memread;
    logic                      id_ex_memwrite;
    logic                      id_ex_valid;
    logic [`PIPE_DATA_W-1:0]   ex_mem_result;
    logic [`PIPE_DATA_W-1:0]   ex_mem_store_data;
    logic [`PIPE_REG_ADDR-1:0] ex_mem_dest;
    logic                      ex_mem_regwrite;
    logic                      ex_mem_memread;
    logic                      ex_mem_memwrite;
    logic                      ex_mem_valid;       // Tracks bubbles alongside EX/MEM
    pipe_pkg::mem_fwd_sel_t    forward_mem;
    logic [`PIPE_DATA_W-1:0]   mem_wr_data;
    logic [`PIPE_DATA_W-1:0]   mem_rd_data;
    logic [`PIPE_DATA_W-1:0]   mem_wb_result;
    logic [`PIPE_REG_ADDR-1:0] mem_wb_dest;
    logic                      mem_wb_regwrite;
    logic                      mem_wb_valid;

    // Read in the issue cycle, written back from MEM/WB
    register_file register_file_inst
    (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (issue_src1),
        .rd_addr2 (issue_src2),
        .wr_en    (mem_wb_regwrite),
        .wr_addr  (mem_wb_dest),
        .wr_data  (mem_wb_result),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2)
    );

    // ID/EX control, an invalid issue turns into a bubble
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            id_ex_valid    <= 1'b0;
            id_ex_regwrite <= 1'b0;
            id_ex_memread  <= 1'b0;
            id_ex_memwrite <= 1'b0;
        end
        else
        begin
            id_ex_valid    <= issue_valid;
            id_ex_regwrite <= issue_valid && issue_regwrite;
            id_ex_memread  <= issue_valid && issue_memread;
            id_ex_memwrite <= issue_valid && issue_memwrite;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        id_ex_op      <= issue_op;
        id_ex_a       <= rf_data1;
        id_ex_b       <= rf_data2;
        id_ex_imm     <= issue_imm;
        id_ex_use_imm <= issue_use_imm;
        id_ex_src1    <= issue_src1;
        id_ex_src2    <= issue_src2;
        id_ex_dest    <= issue_dest;
    end

    execute_stage execute_stage_inst
    (
        .clk               (clk),
        .reset             (reset),
        .id_ex_op          (id_ex_op),
        .id_ex_a           (id_ex_a),
        .id_ex_b           (id_ex_b),
        .id_ex_imm         (id_ex_imm),
        .id_ex_use_imm     (id_ex_use_imm),
        .id_ex_src1        (id_ex_src1),
        .id_ex_src2        (id_ex_src2),
        .id_ex_dest        (id_ex_dest),
        .id_ex_regwrite    (id_ex_regwrite),
        .id_ex_memread     (id_ex_memread),
        .id_ex_memwrite    (id_ex_memwrite),
        .mem_wb_result     (mem_wb_result),
        .mem_wb_regwrite   (mem_wb_regwrite),
        .mem_wb_dest       (mem_wb_dest),
        .ex_mem_result     (ex_mem_result),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_src2       (),                  // Only the forwarding unit needs it
        .ex_mem_dest       (ex_mem_dest),
        .ex_mem_regwrite   (ex_mem_regwrite),
        .ex_mem_memread    (ex_mem_memread),
        .ex_mem_memwrite   (ex_mem_memwrite),
        .forward_mem       (forward_mem)
    );

    // Load then store, the loaded word sits in MEM/WB this cycle
    assign mem_wr_data = (forward_mem == pipe_pkg::mem_fwd_wb) ? mem_wb_result
                                                               : ex_mem_store_data;

    data_memory data_memory_inst
    (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (ex_mem_memwrite),
        .addr    (ex_mem_result),
        .wr_data (mem_wr_data),
        .rd_data (mem_rd_data)
    );

    // Valid, MEM/WB and retire control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_mem_valid    <= 1'b0;
            mem_wb_valid    <= 1'b0;
            mem_wb_regwrite <= 1'b0;
            retire_valid    <= 1'b0;
            retire_regwrite <= 1'b0;
        end
        else
        begin
            ex_mem_valid    <= id_ex_valid;
            mem_wb_valid    <= ex_mem_valid;
            mem_wb_regwrite <= ex_mem_regwrite;
            retire_valid    <= mem_wb_valid;     // Same edge as the register write
            retire_regwrite <= mem_wb_regwrite;
        end
    end

    // MEM/WB and retire payload
    always_ff @(posedge clk)
    begin
        mem_wb_result <= ex_mem_memread ? mem_rd_data : ex_mem_result;
        mem_wb_dest   <= ex_mem_dest;
        retire_dest   <= mem_wb_dest;
        retire_data   <= mem_wb_result;
    end

endmodule

`default_nettype wire

/* test/pipeline_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_cfg.svh"

module pipeline_core_tb;

    localparam int reset_cycles = 2;
    localparam int drain_margin = 20;                 // Cycles allowed past the last slot
    localparam int mem_aw       = $clog2(`PIPE_MEM_DEPTH);
    localparam int retire_depth = 5;                  // Slot pushed 4 edges before its check

    logic                      clk;
    logic                      reset;
    logic                      issue_valid;
    pipe_pkg::alu_op_t         issue_op;
    logic [`PIPE_REG_ADDR-1:0] issue_src1;
    logic [`PIPE_REG_ADDR-1:0] issue_src2;
    logic [`PIPE_REG_ADDR-1:0] issue_dest;
    logic [`PIPE_DATA_W-1:0]   issue_imm;
    logic                      issue_use_imm;
    logic                      issue_regwrite;
    logic                      issue_memread;
    logic                      issue_memwrite;
    logic                      retire_valid;
    logic [`PIPE_REG_ADDR-1:0] retire_dest;
    logic [`PIPE_DATA_W-1:0]   retire_data;
    logic                      retire_regwrite;

    // Shadow state, updated in program order at issue
    logic [`PIPE_DATA_W-1:0]   shadow_regs [1 << `PIPE_REG_ADDR];
    logic [`PIPE_DATA_W-1:0]   shadow_mem [`PIPE_MEM_DEPTH];

    // One entry per driven slot, bubbles included
    logic                      exp_valid_q [$];
    logic                      exp_regwrite_q [$];
    logic [`PIPE_REG_ADDR-1:0] exp_dest_q [$];
    logic [`PIPE_DATA_W-1:0]   exp_data_q [$];
    logic                      exp_valid;
    logic                      exp_regwrite;
    logic [`PIPE_REG_ADDR-1:0] exp_dest;
    logic [`PIPE_DATA_W-1:0]   exp_data;

    int error_count;
    int check_count;
    int slot_count;
    int cycle_count;

    pipeline_core pipeline_core_inst
    (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_src1      (issue_src1),
        .issue_src2      (issue_src2),
        .issue_dest      (issue_dest),
        .issue_imm       (issue_imm),
        .issue_use_imm   (issue_use_imm),
        .issue_regwrite  (issue_regwrite),
        .issue_memread   (issue_memread),
        .issue_memwrite  (issue_memwrite),
        .retire_valid    (retire_valid),
        .retire_dest     (retire_dest),
        .retire_data     (retire_data),
        .retire_regwrite (retire_regwrite)
    );

    always #20 clk = ~clk;  // 40 ns period

    // Integer operations as the ISA defines them
    function automatic logic [`PIPE_DATA_W-1:0] compute_alu
    (
        input pipe_pkg::alu_op_t       op,
        input logic [`PIPE_DATA_W-1:0] a,
        input logic [`PIPE_DATA_W-1:0] b
    );
        logic [4:0] amount;
        amount = b[4:0];  // Shift amount from low 5 bits
        case (op)
            pipe_pkg::alu_add: return a + b;
            pipe_pkg::alu_sub: return a - b;
            pipe_pkg::alu_and: return a & b;
            pipe_pkg::alu_or:  return a | b;
            pipe_pkg::alu_xor: return a ^ b;
            pipe_pkg::alu_sll: return a << amount;
            pipe_pkg::alu_srl: return a >> amount;
            default:           return ($signed(a) < $signed(b)) ? 1 : 0;
        endcase
    endfunction

    task automatic report_mismatch
    (
        input string                   name,
        input logic [`PIPE_DATA_W-1:0] expected,
        input logic [`PIPE_DATA_W-1:0] actual
    );
        error_count++;
        $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    endtask

    // Runs the model for one slot, then drives it at the next rising edge
    task automatic drive_slot
    (
        input logic                      valid,
        input pipe_pkg::alu_op_t         op,
        input logic [`PIPE_REG_ADDR-1:0] src1,
        input logic [`PIPE_REG_ADDR-1:0] src2,
        input logic [`PIPE_REG_ADDR-1:0] dest,
        input logic [`PIPE_DATA_W-1:0]   imm,
        input logic                      use_imm,
        input logic                      regwrite,
        input logic                      memread,
        input logic                      memwrite
    );
        logic [`PIPE_DATA_W-1:0] a;
        logic [`PIPE_DATA_W-1:0] b;
        logic [`PIPE_DATA_W-1:0] result;
        a = shadow_regs[src1];
        b = use_imm ? imm : shadow_regs[src2];
        result = compute_alu(op, a, b);  // Also the load and store address
        if (valid && memread)
            result = shadow_mem[result[mem_aw-1:0]];
        else if (valid && memwrite)
            shadow_mem[result[mem_aw-1:0]] = shadow_regs[src2];
        if (valid && regwrite && dest != 0)
            shadow_regs[dest] = result;
        @(posedge clk);
        issue_valid    <= valid;
        issue_op       <= op;
        issue_src1     <= src1;
        issue_src2     <= src2;
        issue_dest     <= dest;
        issue_imm      <= imm;
        issue_use_imm  <= use_imm;
        issue_regwrite <= regwrite;
        issue_memread  <= memread;
        issue_memwrite <= memwrite;
        exp_valid_q.push_back(valid);
        exp_regwrite_q.push_back(valid && regwrite);
        exp_dest_q.push_back(dest);
        exp_data_q.push_back(result);
        slot_count++;
    endtask

    task automatic alu_reg(input pipe_pkg::alu_op_t op, input int dest, src1, src2);
        drive_slot(1'b1, op, src1, src2, dest, '0, 1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic alu_imm(input pipe_pkg::alu_op_t op, input int dest, src1,
                           input logic [`PIPE_DATA_W-1:0] imm);
        drive_slot(1'b1, op, src1, 0, dest, imm, 1'b1, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic load_word(input int dest, base, offset);
        drive_slot(1'b1, pipe_pkg::alu_add, base, 0, dest, offset, 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic store_word(input int data_reg, base, offset);
        drive_slot(1'b1, pipe_pkg::alu_add, base, data_reg, 0, offset, 1'b1, 1'b0, 1'b0, 1'b1);
    endtask

    // Invalid slot with both write enables raised, issue has to clear them
    task automatic insert_bubble(input int count);
        repeat (count)
            drive_slot(1'b0, pipe_pkg::alu_add, 0, $urandom_range(1, 7), $urandom_range(1, 7),
                       $urandom, 1'b1, 1'b1, 1'b0, 1'b1);
    endtask

    // Retires the register value without writing anything
    task automatic read_reg(input int r);
        drive_slot(1'b1, pipe_pkg::alu_add, r, 0, r, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic random_stream(input int count);
        int                        kind;
        logic [`PIPE_REG_ADDR-1:0] s1;
        logic [`PIPE_REG_ADDR-1:0] s2;
        logic [`PIPE_REG_ADDR-1:0] d;
        logic [`PIPE_REG_ADDR-1:0] load_dest;  // Nonzero right after a load
        load_dest = 0;
        for (int i = 0; i < count; i++)
        begin
            kind = $urandom_range(0, 9);
            s1 = $urandom_range(0, 7);  // Few registers, many hazards
            s2 = $urandom_range(0, 7);
            d  = $urandom_range(0, 7);
            // No load result as an ALU operand in the next slot
            while (load_dest != 0 && s1 == load_dest)
                s1 = $urandom_range(0, 7);
            while (load_dest != 0 && kind > 3 && s2 == load_dest)
                s2 = $urandom_range(0, 7);
            if (kind == 2 && load_dest != 0 && $urandom_range(0, 1))
                s2 = load_dest;  // Store data through the MEM bypass
            load_dest = 0;
            case (kind)
                0, 1:
                begin
                    load_word(d, s1, $urandom_range(0, 63));
                    load_dest = d;
                end
                2:       store_word(s2, s1, $urandom_range(0, 63));
                3:       insert_bubble(1);
                default:
                begin
                    if ($urandom_range(0, 1))
                        alu_imm(pipe_pkg::alu_op_t'($urandom_range(0, 7)), d, s1, $urandom);
                    else
                        alu_reg(pipe_pkg::alu_op_t'($urandom_range(0, 7)), d, s1, s2);
                end
            endcase
        end
    endtask

    // Retire check at the falling edge, outputs are settled
    always @(negedge clk)
    begin
        check_count++;
        if (reset || exp_valid_q.size() < retire_depth)
        begin
            assert (retire_valid === 1'b0)
            else
                report_mismatch("retire_valid", 0, retire_valid);
        end
        else
        begin
            exp_valid    = exp_valid_q.pop_front();
            exp_regwrite = exp_regwrite_q.pop_front();
            exp_dest     = exp_dest_q.pop_front();
            exp_data     = exp_data_q.pop_front();
            assert (retire_valid === exp_valid)
            else
                report_mismatch("retire_valid", exp_valid, retire_valid);
            if (exp_valid)
            begin
                assert (retire_regwrite === exp_regwrite)
                else
                    report_mismatch("retire_regwrite", exp_regwrite, retire_regwrite);
                assert (retire_dest === exp_dest)
                else
                    report_mismatch("retire_dest", exp_dest, retire_dest);
                assert (retire_data === exp_data)
                else
                    report_mismatch("retire_data", exp_data, retire_data);
            end
        end
    end

    // Hang guard, limit grows with every slot driven
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > slot_count + reset_cycles + drain_margin)
        begin
            error_count++;
            $display("Timeout: stimulus stopped advancing after %0d cycles", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(45879));
        clk            = 1'b0;
        reset          = 1'b1;
        issue_valid    = 1'b0;
        issue_op       = pipe_pkg::alu_add;
        issue_src1     = '0;
        issue_src2     = '0;
        issue_dest     = '0;
        issue_imm      = '0;
        issue_use_imm  = 1'b0;
        issue_regwrite = 1'b0;
        issue_memread  = 1'b0;
        issue_memwrite = 1'b0;
        for (int i = 0; i < (1 << `PIPE_REG_ADDR); i++)
            shadow_regs[i] = '0;
        for (int i = 0; i < `PIPE_MEM_DEPTH; i++)
            shadow_mem[i] = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        for (int r = 0; r < (1 << `PIPE_REG_ADDR); r++)
            read_reg(r);  // All cleared by reset

        alu_imm(pipe_pkg::alu_add, 1, 0, 5);
        alu_imm(pipe_pkg::alu_add, 2, 1, 3);      // a from EX/MEM
        alu_reg(pipe_pkg::alu_add, 3, 1, 2);      // a from MEM/WB, b from EX/MEM
        alu_reg(pipe_pkg::alu_sub, 4, 2, 3);      // Negative result
        alu_reg(pipe_pkg::alu_xor, 5, 4, 3);      // a from EX/MEM, b from MEM/WB
        alu_imm(pipe_pkg::alu_add, 6, 0, 100);
        alu_imm(pipe_pkg::alu_add, 6, 0, 200);
        alu_reg(pipe_pkg::alu_add, 7, 6, 6);      // Newer r6 must win
        alu_reg(pipe_pkg::alu_slt, 8, 4, 7);
        alu_imm(pipe_pkg::alu_sll, 9, 8, 4);
        alu_reg(pipe_pkg::alu_srl, 10, 4, 9);
        alu_reg(pipe_pkg::alu_or, 11, 10, 9);
        alu_reg(pipe_pkg::alu_and, 12, 11, 4);

        // Three apart goes through the register file write-through
        alu_imm(pipe_pkg::alu_add, 13, 0, 32'h1234_5678);
        alu_imm(pipe_pkg::alu_add, 14, 0, 1);
        alu_imm(pipe_pkg::alu_add, 15, 0, 2);
        alu_reg(pipe_pkg::alu_add, 16, 13, 0);
        alu_reg(pipe_pkg::alu_add, 17, 14, 15);
        alu_imm(pipe_pkg::alu_add, 0, 0, 77);     // r0 stays zero
        read_reg(0);
        read_reg(0);
        read_reg(0);

        alu_imm(pipe_pkg::alu_add, 20, 0, 8);
        alu_imm(pipe_pkg::alu_add, 21, 0, 32'hdead_beef);
        store_word(21, 20, 2);
        load_word(22, 20, 2);                     // Right behind the store
        insert_bubble(1);
        alu_reg(pipe_pkg::alu_add, 23, 22, 0);
        load_word(24, 20, 2);
        store_word(24, 20, 5);                    // Loaded word bypassed in MEM
        insert_bubble(2);
        load_word(25, 20, 5);
        insert_bubble(1);
        read_reg(25);

        random_stream(300);
        insert_bubble(retire_depth);              // Last instruction retires and is checked

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/pipe_pkg.sv
src/forwarding_control.sv
src/register_file.sv
execute/alu.sv
execute/execute_stage.sv
src/data_memory.sv
src/pipeline_core.sv
test/pipeline_core_tb.sv
